//--- lane_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module lane_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_push,
    input  logic [WIDTH-1:0]           i_din,
    input  logic                       i_pop,
    output logic [WIDTH-1:0]           o_dout,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] used;
    logic             do_push;
    logic             do_pop;

    // wraps at DEPTH, not only at a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        ptr_next = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign o_empty = (used == '0);
    assign o_full  = (used == CNT_W'(DEPTH));
    assign o_count = CNT_W'(DEPTH) - used;  // free slots
    assign o_dout  = mem[rd_ptr];           // show-ahead head

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            used   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;  // idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

//--- stream_in_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module stream_in_buffer import vmac_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  vec_t              i_tdata,
    input  logic [KEEP_W-1:0] i_tkeep,
    input  logic              i_tvalid,
    output logic              o_tready,
    output vec_t              o_beat,
    output logic              o_beat_avail,
    input  logic              i_beat_take
);

    logic [LANES-1:0] lane_push;
    logic [LANES-1:0] lane_full;
    logic [LANES-1:0] lane_empty;

    // accept only while every lane can take a word
    assign o_tready = ~|lane_full;

    // a beat is usable once all four lanes hold data
    assign o_beat_avail = ~|lane_empty;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        // both keep bits of the lane must be set
        assign lane_push[l] = i_tvalid && o_tready
                              && (&i_tkeep[l*(KEEP_W/LANES) +: (KEEP_W/LANES)]);

        lane_fifo #(
            .WIDTH (LANE_W),
            .DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_push  (lane_push[l]),
            .i_din   (i_tdata[l*LANE_W +: LANE_W]),
            .i_pop   (i_beat_take),  // joint pop over lanes
            .o_dout  (o_beat[l*LANE_W +: LANE_W]),
            .o_empty (lane_empty[l]),
            .o_full  (lane_full[l]),
            .o_count ()
        );
    end

endmodule

`default_nettype wire

//--- stream_out_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module stream_out_buffer import vmac_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_push,
    input  vec_t              i_data,
    input  logic              i_last,
    output vec_t              o_tdata,
    output logic [KEEP_W-1:0] o_tkeep,
    output logic              o_tvalid,
    output logic              o_tlast,
    input  logic              i_tready,
    output logic              o_room
);

    logic [LANES-1:0]      lane_empty;
    logic [LANES-1:0]      lane_last;
    logic [FIFO_CNT_W-1:0] lane_free [LANES];
    logic [FIFO_CNT_W-1:0] min_free;
    logic                  pop;

    assign o_tvalid = ~|lane_empty;
    assign o_tlast  = o_tvalid && (&lane_last);  // head is stale while empty
    assign pop      = o_tvalid && i_tready;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        assign o_tkeep[l*(KEEP_W/LANES) +: (KEEP_W/LANES)] = {(KEEP_W/LANES){!lane_empty[l]}};

        // last flag travels as the top bit of each lane word
        lane_fifo #(
            .WIDTH (LANE_W + 1),
            .DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_push  (i_push),
            .i_din   ({i_last, i_data[l*LANE_W +: LANE_W]}),
            .i_pop   (pop),
            .o_dout  ({lane_last[l], o_tdata[l*LANE_W +: LANE_W]}),
            .o_empty (lane_empty[l]),
            .o_full  (),
            .o_count (lane_free[l])
        );
    end

    always_comb begin
        min_free = lane_free[0];
        for (int l = 1; l < LANES; l++) begin
            if (lane_free[l] < min_free) begin
                min_free = lane_free[l];
            end
        end
    end

    // room for every step in flight plus the one about to issue
    assign o_room = (min_free >= FIFO_CNT_W'(PE_LATENCY + 1));

endmodule

`default_nettype wire

//--- tb_vmac.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vmac import vmac_pkg::*; ();

    logic                 clk;
    logic                 rst;
    logic                 i_cmd_start;
    vop_t                 i_cmd_op;
    logic [RF_ADDR_W-1:0] i_cmd_dst;
    logic [RF_ADDR_W-1:0] i_cmd_src;
    logic [LEN_W-1:0]     i_cmd_len;
    vec_t                 i_tdata_in;
    logic [KEEP_W-1:0]    i_tkeep_in;
    logic                 i_tvalid_in;
    logic                 o_tready_in;
    vec_t                 o_tdata_out;
    logic [KEEP_W-1:0]    o_tkeep_out;
    logic                 o_tvalid_out;
    logic                 o_tlast_out;
    logic                 i_tready_out;
    logic                 o_busy;
    logic                 o_done;

    // command table, one entry per command
    string t_name [$];
    vop_t  t_op [$];
    int    t_dst [$];
    int    t_src [$];
    int    t_len [$];
    int    t_base [$];   // first input beat of the command
    bit    t_stall [$];  // random output back-pressure
    bit    t_poke [$];   // extra start pulse while busy
    vec_t  beats [$];

    vec_t   model [RF_DEPTH];
    vec_t   exp_data [$];
    logic   exp_last [$];
    int     pending;
    int     done_count;
    int     limit_cycles;
    bit     stall_en;
    integer seed;
    string  test_name;

    vmac_engine dut0 (
        .clk          (clk),
        .rst          (rst),
        .i_cmd_start  (i_cmd_start),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_dst    (i_cmd_dst),
        .i_cmd_src    (i_cmd_src),
        .i_cmd_len    (i_cmd_len),
        .i_tdata_in   (i_tdata_in),
        .i_tkeep_in   (i_tkeep_in),
        .i_tvalid_in  (i_tvalid_in),
        .o_tready_in  (o_tready_in),
        .o_tdata_out  (o_tdata_out),
        .o_tkeep_out  (o_tkeep_out),
        .o_tvalid_out (o_tvalid_out),
        .o_tlast_out  (o_tlast_out),
        .i_tready_out (i_tready_out),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_vec(input string what, input vec_t exp, input vec_t act);
        if (exp !== act) begin
            $display("ERR %s (%s): expected %h actual %h", test_name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s (%s): expected %b actual %b", test_name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_keep(input string what, input logic [KEEP_W-1:0] exp,
                              input logic [KEEP_W-1:0] act);
        if (exp !== act) begin
            $display("ERR %s (%s): expected %h actual %h", test_name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("ERR %s (%s): expected %0d actual %0d", test_name, what, exp, act);
            fail_run();
        end
    endtask

    // lane-wise acc + b * s, every lane wraps at 16 bits
    function automatic vec_t mac_lanes(input vec_t acc, input vec_t b, input vec_t s);
        vec_t  r;
        lane_t p;
        for (int l = 0; l < LANES; l++) begin
            p = b[l*LANE_W +: LANE_W] * s[l*LANE_W +: LANE_W];
            r[l*LANE_W +: LANE_W] = acc[l*LANE_W +: LANE_W] + p;
        end
        return r;
    endfunction

    task automatic add_cmd(input string name, input vop_t op, input int dst, input int src,
                           input int len, input bit stall, input bit poke);
        t_name.push_back(name);
        t_op.push_back(op);
        t_dst.push_back(dst);
        t_src.push_back(src);
        t_len.push_back(len);
        t_base.push_back(beats.size());
        t_stall.push_back(stall);
        t_poke.push_back(poke);
        if ((op == OP_LOAD) || (op == OP_MACC)) begin
            for (int i = 0; i < len; i++) begin
                beats.push_back({$random(seed), $random(seed)});
            end
        end
    endtask

    // expected register contents and output beats
    task automatic apply_model(input int c);
        int d;
        int s;
        for (int i = 0; i < t_len[c]; i++) begin
            d = (t_dst[c] + i) % RF_DEPTH;
            s = (t_src[c] + i) % RF_DEPTH;
            case (t_op[c])
                OP_ZERO: model[d] = '0;
                OP_LOAD: model[d] = beats[t_base[c] + i];
                OP_MACC: model[d] = mac_lanes(model[d], beats[t_base[c] + i], model[s]);
                default: begin
                    exp_data.push_back(model[s]);
                    exp_last.push_back(i == t_len[c] - 1);
                    pending++;
                end
            endcase
        end
    endtask

    task automatic start_pulse(input vop_t op, input int dst, input int src, input int len);
        @(posedge clk);
        i_cmd_start <= 1'b1;
        i_cmd_op    <= op;
        i_cmd_dst   <= RF_ADDR_W'(dst);
        i_cmd_src   <= RF_ADDR_W'(src);
        i_cmd_len   <= LEN_W'(len);
        @(posedge clk);
        i_cmd_start <= 1'b0;
    endtask

    task automatic feed_beats(input int c);
        int idx;
        bit gap;
        idx = 0;
        if ((t_op[c] == OP_LOAD) || (t_op[c] == OP_MACC)) begin
            while (idx < t_len[c]) begin
                @(posedge clk);
                gap = ($unsigned($random(seed)) % 4) == 0;
                i_tvalid_in <= !gap;
                i_tdata_in  <= beats[t_base[c] + idx];
                @(negedge clk);
                if (i_tvalid_in && o_tready_in) begin
                    idx++;  // taken at the coming edge
                end
            end
            @(posedge clk);
            i_tvalid_in <= 1'b0;
        end
    endtask

    // a second start that the busy engine must ignore
    task automatic poke_busy(input int c);
        if (t_poke[c]) begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_bit("busy before extra start", 1'b1, o_busy);
            start_pulse(OP_ZERO, 0, 0, RF_DEPTH);
        end
    endtask

    task automatic wait_done(input int c);
        wait (done_count == c + 1);
        wait (pending == 0);
        repeat (3) @(negedge clk);
        check_count("done pulses", c + 1, done_count);
        check_bit("busy after done", 1'b0, o_busy);
    endtask

    // output side and done counting, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (o_done) begin
                done_count++;
                check_bit("busy low with done", 1'b0, o_busy);
            end
            if (o_tvalid_out && i_tready_out) begin
                if (pending == 0) begin
                    $display("output beat seen in %s while none was expected", test_name);
                    fail_run();
                end
                check_vec("stream out data", exp_data[0], o_tdata_out);
                check_bit("stream out last", exp_last[0], o_tlast_out);
                check_keep("stream out keep", {KEEP_W{1'b1}}, o_tkeep_out);
                void'(exp_data.pop_front());
                void'(exp_last.pop_front());
                pending--;
            end
        end
    end

    always @(posedge clk) begin
        if (stall_en) begin
            i_tready_out <= ($unsigned($random(seed)) % 3) != 0;
        end else begin
            i_tready_out <= 1'b1;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles in %s", limit_cycles, test_name);
        fail_run();
    end

    initial begin
        int total;
        clk          = 1'b0;
        rst          = 1'b1;
        i_cmd_start  = 1'b0;
        i_cmd_op     = OP_ZERO;
        i_cmd_dst    = '0;
        i_cmd_src    = '0;
        i_cmd_len    = '0;
        i_tdata_in   = '0;
        i_tkeep_in   = {KEEP_W{1'b1}};
        i_tvalid_in  = 1'b0;
        i_tready_out = 1'b1;
        stall_en     = 1'b0;
        pending      = 0;
        done_count   = 0;
        limit_cycles = 0;
        seed         = 97920;
        test_name    = "reset";
        total        = 0;

        add_cmd("zero all", OP_ZERO, 0, 0, 16, 0, 0);
        add_cmd("stream zeros", OP_STREAMOUT, 0, 0, 16, 0, 0);
        add_cmd("load run", OP_LOAD, 2, 0, 6, 0, 0);
        add_cmd("stream loaded run", OP_STREAMOUT, 0, 2, 6, 0, 0);
        add_cmd("load sources", OP_LOAD, 8, 0, 4, 0, 0);
        add_cmd("load accumulators", OP_LOAD, 12, 0, 4, 0, 0);
        add_cmd("macc first", OP_MACC, 12, 8, 4, 0, 0);
        add_cmd("macc second", OP_MACC, 12, 8, 4, 0, 0);
        add_cmd("stream sums", OP_STREAMOUT, 0, 12, 4, 1, 0);
        add_cmd("load wrap", OP_LOAD, 14, 0, 4, 0, 0);
        add_cmd("stream wrap stalled", OP_STREAMOUT, 0, 14, 4, 1, 0);
        add_cmd("start while busy", OP_STREAMOUT, 0, 0, 16, 1, 1);
        add_cmd("recheck after ignored start", OP_STREAMOUT, 0, 0, 16, 0, 0);

        foreach (t_len[c]) begin
            total += t_len[c];
        end
        limit_cycles = 200 * total + 2000;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("busy after reset", 1'b0, o_busy);
        check_bit("done after reset", 1'b0, o_done);
        check_bit("tvalid out after reset", 1'b0, o_tvalid_out);
        check_bit("tlast out after reset", 1'b0, o_tlast_out);
        check_bit("tready in after reset", 1'b1, o_tready_in);
        check_keep("tkeep out after reset", '0, o_tkeep_out);

        for (int c = 0; c < t_op.size(); c++) begin
            test_name = t_name[c];
            apply_model(c);
            stall_en = t_stall[c];
            start_pulse(t_op[c], t_dst[c], t_src[c], t_len[c]);
            fork
                feed_beats(c);
                poke_busy(c);
                wait_done(c);
            join
            stall_en = 1'b0;
        end

        test_name = "final";
        repeat (10) @(negedge clk);
        if ((pending == 0) && (done_count == t_op.size())) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("run ended with %0d beats missing and %0d done pulses", pending, done_count);
            fail_run();
        end
    end

endmodule

`default_nettype wire

//--- vector_mac_pe.sv
`timescale 1ns/100ps
`default_nettype none

module vector_mac_pe import vmac_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  vec_t    i_beat,
    vreg_port_if.pe port,
    output logic    o_out_push,
    output vec_t    o_out_data,
    output logic    o_out_last
);

    // stage 1
    logic                 s1_valid;
    logic                 s1_last;
    vop_t                 s1_op;
    logic [RF_ADDR_W-1:0] s1_addr;
    vec_t                 s1_beat;
    vec_t                 s1_src;
    vec_t                 s1_dst;
    lane_t                prod [LANES];
    vec_t                 result;

    // stage 2
    logic                 s2_wb;
    logic                 s2_push;
    logic                 s2_last;
    logic [RF_ADDR_W-1:0] s2_addr;
    vec_t                 s2_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= port.rd_valid;
            s1_last  <= port.rd_valid && port.rd_last;
        end
    end

    always_ff @(posedge clk) begin
        s1_op   <= port.rd_op;
        s1_addr <= port.rd_addr;
        s1_beat <= i_beat;   // head of the input fifos on issue
        s1_src  <= port.rd_src;
        s1_dst  <= port.rd_dst;
    end

    // products and select, all lanes wrap at 16 bits
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            prod[l] = s1_beat[l*LANE_W +: LANE_W] * s1_src[l*LANE_W +: LANE_W];
            case (s1_op)
                OP_ZERO: result[l*LANE_W +: LANE_W] = '0;
                OP_LOAD: result[l*LANE_W +: LANE_W] = s1_beat[l*LANE_W +: LANE_W];
                OP_MACC: result[l*LANE_W +: LANE_W] = s1_dst[l*LANE_W +: LANE_W] + prod[l];
                default: result[l*LANE_W +: LANE_W] = s1_src[l*LANE_W +: LANE_W];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_wb   <= 1'b0;
            s2_push <= 1'b0;
            s2_last <= 1'b0;
        end else begin
            s2_wb   <= s1_valid && (s1_op != OP_STREAMOUT);
            s2_push <= s1_valid && (s1_op == OP_STREAMOUT);  // streamout writes nothing
            s2_last <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        s2_addr <= s1_addr;
        s2_data <= result;
    end

    assign port.wb_en       = s2_wb;
    assign port.wb_addr     = s2_addr;
    assign port.wb_data     = s2_data;
    assign port.retire_last = s2_last;

    assign o_out_push = s2_push;
    assign o_out_data = s2_data;
    assign o_out_last = s2_last;

endmodule

`default_nettype wire

//--- vmac.f
vmac_pkg.sv
vreg_port_if.sv
lane_fifo.sv
stream_in_buffer.sv
vreg_sweep.sv
vector_mac_pe.sv
stream_out_buffer.sv
vmac_engine.sv
tb_vmac.sv

//--- vmac_engine.sv
`timescale 1ns/100ps
`default_nettype none

module vmac_engine import vmac_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // command
    input  logic                 i_cmd_start,
    input  vop_t                 i_cmd_op,
    input  logic [RF_ADDR_W-1:0] i_cmd_dst,
    input  logic [RF_ADDR_W-1:0] i_cmd_src,
    input  logic [LEN_W-1:0]     i_cmd_len,
    // stream in
    input  vec_t                 i_tdata_in,
    input  logic [KEEP_W-1:0]    i_tkeep_in,
    input  logic                 i_tvalid_in,
    output logic                 o_tready_in,
    // stream out
    output vec_t                 o_tdata_out,
    output logic [KEEP_W-1:0]    o_tkeep_out,
    output logic                 o_tvalid_out,
    output logic                 o_tlast_out,
    input  logic                 i_tready_out,
    // status
    output logic                 o_busy,
    output logic                 o_done
);

    vec_t beat;
    logic beat_avail;
    logic beat_take;
    logic out_push;
    vec_t out_data;
    logic out_last;
    logic out_room;

    vreg_port_if vport ();

    stream_in_buffer u_stream_in (
        .clk          (clk),
        .rst          (rst),
        .i_tdata      (i_tdata_in),
        .i_tkeep      (i_tkeep_in),
        .i_tvalid     (i_tvalid_in),
        .o_tready     (o_tready_in),
        .o_beat       (beat),
        .o_beat_avail (beat_avail),
        .i_beat_take  (beat_take)
    );

    vreg_sweep u_sweep (
        .clk          (clk),
        .rst          (rst),
        .i_cmd_start  (i_cmd_start),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_dst    (i_cmd_dst),
        .i_cmd_src    (i_cmd_src),
        .i_cmd_len    (i_cmd_len),
        .i_beat_avail (beat_avail),
        .o_beat_take  (beat_take),
        .i_out_room   (out_room),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .port         (vport.sweep)
    );

    vector_mac_pe u_pe (
        .clk        (clk),
        .rst        (rst),
        .i_beat     (beat),
        .port       (vport.pe),
        .o_out_push (out_push),
        .o_out_data (out_data),
        .o_out_last (out_last)
    );

    stream_out_buffer u_stream_out (
        .clk      (clk),
        .rst      (rst),
        .i_push   (out_push),
        .i_data   (out_data),
        .i_last   (out_last),
        .o_tdata  (o_tdata_out),
        .o_tkeep  (o_tkeep_out),
        .o_tvalid (o_tvalid_out),
        .o_tlast  (o_tlast_out),
        .i_tready (i_tready_out),
        .o_room   (out_room)
    );

endmodule

`default_nettype wire

//--- vmac_pkg.sv
`default_nettype none

package vmac_pkg;

    // lane geometry
    localparam int LANES  = 4;
    localparam int LANE_W = 16;
    localparam int PHIT_W = LANES * LANE_W;   // 64-bit stream word
    localparam int KEEP_W = PHIT_W / 8;       // two keep bits per lane

    // vector register file
    localparam int RF_DEPTH  = 16;
    localparam int RF_ADDR_W = 4;
    localparam int LEN_W     = 5;             // run length 1..16

    // buffering
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // fixed depth of the mac pipeline
    localparam int PE_LATENCY = 2;

    // one 16-bit integer lane, arithmetic wraps
    typedef logic [LANE_W-1:0] lane_t;

    // lane 0 sits in the low bits
    typedef logic [PHIT_W-1:0] vec_t;

    typedef enum logic [1:0] {
        OP_ZERO      = 2'd0,  // clear entries
        OP_LOAD      = 2'd1,  // entries from stream
        OP_MACC      = 2'd2,  // dst += beat * src
        OP_STREAMOUT = 2'd3   // entries to output stream
    } vop_t;

endpackage

`default_nettype wire

//--- vreg_port_if.sv
`timescale 1ns/100ps
`default_nettype none

interface vreg_port_if import vmac_pkg::*; ();

    // issue side, one step per rd_valid
    logic                 rd_valid;
    vop_t                 rd_op;      // opcode rides with the step
    logic [RF_ADDR_W-1:0] rd_addr;    // destination entry
    vec_t                 rd_src;
    vec_t                 rd_dst;
    logic                 rd_last;

    // retire side
    logic                 wb_en;
    logic [RF_ADDR_W-1:0] wb_addr;
    vec_t                 wb_data;
    logic                 retire_last;

    modport sweep (
        output rd_valid, rd_op, rd_addr, rd_src, rd_dst, rd_last,
        input  wb_en, wb_addr, wb_data, retire_last
    );

    modport pe (
        input  rd_valid, rd_op, rd_addr, rd_src, rd_dst, rd_last,
        output wb_en, wb_addr, wb_data, retire_last
    );

endinterface

`default_nettype wire

//--- vreg_sweep.sv
`timescale 1ns/100ps
`default_nettype none

module vreg_sweep import vmac_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_cmd_start,
    input  vop_t                 i_cmd_op,
    input  logic [RF_ADDR_W-1:0] i_cmd_dst,
    input  logic [RF_ADDR_W-1:0] i_cmd_src,
    input  logic [LEN_W-1:0]     i_cmd_len,
    input  logic                 i_beat_avail,
    output logic                 o_beat_take,
    input  logic                 i_out_room,
    output logic                 o_busy,
    output logic                 o_done,
    vreg_port_if.sweep           port
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,  // stepping through the run
        ST_DRAIN   // waiting for the last step to leave the pe
    } state_t;

    state_t               state;
    vop_t                 op;
    logic [LEN_W-1:0]     remaining;
    logic [RF_ADDR_W-1:0] dst_ptr;
    logic [RF_ADDR_W-1:0] src_ptr;
    logic                 step_ok;
    logic                 issue;
    logic                 last_step;

    vec_t rf [RF_DEPTH];

    // per-opcode condition for issuing a step
    always_comb begin
        case (op)
            OP_ZERO:      step_ok = 1'b1;
            OP_LOAD:      step_ok = i_beat_avail;
            OP_MACC:      step_ok = i_beat_avail;
            OP_STREAMOUT: step_ok = i_out_room;
            default:      step_ok = 1'b0;
        endcase
    end

    assign issue       = (state == ST_ISSUE) && step_ok;
    assign last_step   = (remaining == LEN_W'(1));
    assign o_beat_take = issue && ((op == OP_LOAD) || (op == OP_MACC));
    assign o_busy      = (state != ST_IDLE);

    // both reads are combinational on the issue cycle
    assign port.rd_valid = issue;
    assign port.rd_op    = op;
    assign port.rd_addr  = dst_ptr;
    assign port.rd_src   = rf[src_ptr];
    assign port.rd_dst   = rf[dst_ptr];
    assign port.rd_last  = last_step;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            op        <= OP_ZERO;
            remaining <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // a zero length run is dropped
                    if (i_cmd_start && (i_cmd_len != '0)) begin
                        op        <= i_cmd_op;
                        remaining <= i_cmd_len;
                        state     <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (issue) begin
                        remaining <= remaining - 1'b1;
                        if (last_step) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (port.retire_last) begin
                        state  <= ST_IDLE;
                        o_done <= 1'b1;  // lands with busy falling
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address sweep, wraps naturally past entry 15
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && i_cmd_start) begin
            dst_ptr <= i_cmd_dst;
            src_ptr <= i_cmd_src;
        end else if (issue) begin
            dst_ptr <= dst_ptr + 1'b1;
            src_ptr <= src_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.wb_en) begin
            rf[port.wb_addr] <= port.wb_data;
        end
    end

endmodule

`default_nettype wire
